// ==== all.f ====
pkt_mux_pkg.sv
axis_if.sv
axis_fifo.sv
axis_mux_rr.sv
pkt_stats.sv
pkt_mux_top.sv
tb_pkt_mux.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        := tb_pkt_mux
RTL_TOP    := pkt_mux_top
FILELIST   := all.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

# The log decides the result, since tee hides the simulator's exit status.
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== pkt_mux_vectors.txt ====
# p phase stream length first_byte_hex
# c stream expected_packet_count
p 1 0 3 10
p 1 0 5 20
p 1 0 4 30
p 1 1 2 40
p 1 1 6 50
p 1 2 1 60
p 1 2 1 70
p 1 2 4 80
p 1 3 7 fc
p 2 0 9 a0
p 2 0 2 b0
p 2 1 16 c0
p 2 1 3 d0
p 2 1 1 e0
p 2 2 5 f0
p 2 3 2 01
p 2 3 8 f8
p 2 3 20 11
c 0 5
c 1 5
c 2 4
c 3 4

// ==== tb_pkt_mux.sv ====
`timescale 1ns/1ns

module tb_pkt_mux;
  import pkt_mux_pkg::*;

  localparam int max_pkts   = 64;
  localparam int wait_limit = 5000;

  logic                               clk;
  logic                               rst_n;
  logic [nr_of_streams*tdata_width-1:0] s_tdata;
  logic [nr_of_streams-1:0]           s_tvalid;
  logic [nr_of_streams-1:0]           s_tlast;
  logic [nr_of_streams-1:0]           s_tready;
  logic [tdata_width-1:0]             m_tdata;
  logic                               m_tvalid;
  logic                               m_tlast;
  logic [tid_width-1:0]               m_tid;
  logic                               m_tready;
  logic                               stat_req;
  logic [tid_width-1:0]               stat_sel;
  logic                               stat_ack;
  logic [stat_width-1:0]              stat_count;

  // Packet list as read from the vector file.
  int pkt_phase  [max_pkts];
  int pkt_stream [max_pkts];
  int pkt_len    [max_pkts];
  int pkt_first  [max_pkts];
  int nr_pkts;
  int exp_cnt [nr_of_streams];

  // Beats still to send and still expected as {tlast, tdata}.
  logic [tdata_width:0] in_q  [nr_of_streams][$];
  logic [tdata_width:0] exp_q [nr_of_streams][$];
  int                   order_q [$];

  logic [31:0]              lfsr;
  logic [nr_of_streams-1:0] stream_en;
  bit                       gaps_on;
  bit                       bp_on;
  bit                       in_pkt;
  logic [tid_width-1:0]     cur_tid;

  pkt_mux_top #(
    .fifo_depth_p    (16),
    .nr_of_streams_p (nr_of_streams)
  ) i_pkt_mux_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .s_tdata    (s_tdata),
    .s_tvalid   (s_tvalid),
    .s_tlast    (s_tlast),
    .s_tready   (s_tready),
    .m_tdata    (m_tdata),
    .m_tvalid   (m_tvalid),
    .m_tlast    (m_tlast),
    .m_tid      (m_tid),
    .m_tready   (m_tready),
    .stat_req   (stat_req),
    .stat_sel   (stat_sel),
    .stat_ack   (stat_ack),
    .stat_count (stat_count)
  );

  always #5 clk = ~clk;

  // Galois LFSR stepped once per random bit.
  function automatic logic next_rand_bit();
    logic fb;
    fb = lfsr[0];
    lfsr = lfsr >> 1;
    if (fb) begin
      lfsr = lfsr ^ 32'h80200003;
    end
    return fb;
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped at the first failure.");
  endtask

  task automatic check_data(input logic [tdata_width-1:0] got,
                            input logic [tdata_width-1:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_tid(input logic [tid_width-1:0] got,
                           input logic [tid_width-1:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_count(input logic [stat_width-1:0] got,
                             input logic [stat_width-1:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic load_vectors();
    int    fd;
    int    code;
    int    phase;
    int    stream;
    int    len;
    int    first;
    int    tally [nr_of_streams];
    string line;
    fd = $fopen("pkt_mux_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open pkt_mux_vectors.txt for reading.");
    end
    nr_pkts = 0;
    for (int s = 0; s < nr_of_streams; s++) begin
      tally[s]   = 0;
      exp_cnt[s] = 0;
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line[0] == "p") begin
        code = $sscanf(line.substr(1, line.len() - 1), "%d %d %d %h", phase, stream, len, first);
        if (code != 4 || nr_pkts == max_pkts || stream < 0 || stream >= nr_of_streams) begin
          abort_run("The vector file holds a packet line that cannot be used.");
        end
        pkt_phase[nr_pkts]  = phase;
        pkt_stream[nr_pkts] = stream;
        pkt_len[nr_pkts]    = len;
        pkt_first[nr_pkts]  = first;
        tally[stream]++;
        nr_pkts++;
      end else if (code > 0 && line.len() > 1 && line[0] == "c") begin
        code = $sscanf(line.substr(1, line.len() - 1), "%d %d", stream, len);
        if (code != 2 || stream < 0 || stream >= nr_of_streams) begin
          abort_run("The vector file holds a count line that cannot be used.");
        end
        exp_cnt[stream] = len;
      end
    end
    $fclose(fd);
    for (int s = 0; s < nr_of_streams; s++) begin
      if (tally[s] != exp_cnt[s]) begin
        abort_run($sformatf("Vector file count for stream %0d disagrees with its packets.", s));
      end
    end
  endtask

  // Bytes count up from the first byte and wrap at 256.
  task automatic queue_packets(input int phase);
    logic [tdata_width:0] beat;
    for (int p = 0; p < nr_pkts; p++) begin
      if (pkt_phase[p] == phase) begin
        for (int k = 0; k < pkt_len[p]; k++) begin
          beat = {k == pkt_len[p] - 1, tdata_width'(pkt_first[p] + k)};
          in_q[pkt_stream[p]].push_back(beat);
          exp_q[pkt_stream[p]].push_back(beat);
        end
      end
    end
  endtask

  // Cyclic order from stream 0 that skips streams with nothing left.
  task automatic plan_rr_order();
    int left [nr_of_streams];
    int total;
    int ptr;
    int s;
    total = 0;
    for (int i = 0; i < nr_of_streams; i++) begin
      left[i] = 0;
    end
    for (int p = 0; p < nr_pkts; p++) begin
      if (pkt_phase[p] == 1) begin
        left[pkt_stream[p]]++;
        total++;
      end
    end
    ptr = 0;
    while (total > 0) begin
      s = ptr;
      while (left[s] == 0) begin
        s = (s + 1) % nr_of_streams;
      end
      order_q.push_back(s);
      left[s]--;
      total--;
      ptr = (s + 1) % nr_of_streams;
    end
  endtask

  task automatic check_out_beat();
    logic [tdata_width:0] beat;
    if (!in_pkt) begin
      cur_tid = m_tid;
      if (order_q.size() > 0) begin
        check_tid(m_tid, tid_width'(order_q.pop_front()), "m_tid of next round-robin packet");
      end
    end else begin
      check_tid(m_tid, cur_tid, "m_tid inside a packet");
    end
    if (exp_q[m_tid].size() == 0) begin
      abort_run($sformatf("Extra output beat at %0t ns from stream %0d.", $time, m_tid));
    end
    beat = exp_q[m_tid].pop_front();
    check_data(m_tdata, beat[tdata_width-1:0], $sformatf("m_tdata of stream %0d", m_tid));
    check_bit(m_tlast, beat[tdata_width], $sformatf("m_tlast of stream %0d", m_tid));
    in_pkt = !m_tlast;
  endtask

  // Sample at the falling edge and drive 1 ns after the rising edge.
  task automatic run_cycle();
    logic [nr_of_streams-1:0] fired;
    logic                     out_fire;
    @(negedge clk);
    fired    = s_tvalid & s_tready;
    out_fire = m_tvalid && m_tready;
    if (out_fire) begin
      check_out_beat();
    end
    @(posedge clk);
    #1;
    for (int s = 0; s < nr_of_streams; s++) begin
      if (fired[s]) begin
        void'(in_q[s].pop_front());
        s_tvalid[s] = 1'b0;
      end
      if (!s_tvalid[s] && stream_en[s] && in_q[s].size() > 0) begin
        if (!gaps_on || next_rand_bit() || next_rand_bit()) begin
          s_tdata[s*tdata_width +: tdata_width] = in_q[s][0][tdata_width-1:0];
          s_tlast[s]  = in_q[s][0][tdata_width];
          s_tvalid[s] = 1'b1;
        end
      end
    end
    if (bp_on) begin
      m_tready = next_rand_bit() | next_rand_bit();
    end
  endtask

  function automatic bit all_sent();
    bit done;
    done = (s_tvalid == '0);
    for (int s = 0; s < nr_of_streams; s++) begin
      done = done && (in_q[s].size() == 0);
    end
    return done;
  endfunction

  function automatic bit all_received();
    bit done;
    done = 1'b1;
    for (int s = 0; s < nr_of_streams; s++) begin
      done = done && (exp_q[s].size() == 0);
    end
    return done;
  endfunction

  task automatic run_until_idle(input bit need_out, input string what);
    int n;
    n = 0;
    while (!all_sent() || (need_out && !all_received())) begin
      run_cycle();
      n++;
      if (n > wait_limit) begin
        abort_run($sformatf("Timed out at %0t ns waiting for %s.", $time, what));
      end
    end
  endtask

  task automatic wait_out_valid();
    int n;
    n = 0;
    while (!m_tvalid) begin
      run_cycle();
      n++;
      if (n > wait_limit) begin
        abort_run("Timed out waiting for the first stream 0 beat at the output.");
      end
    end
  endtask

  task automatic read_count(input int sel, output logic [stat_width-1:0] count);
    int n;
    @(posedge clk);
    #1;
    stat_sel = tid_width'(sel);
    stat_req = 1'b1;
    n = 0;
    while (!stat_ack) begin
      @(posedge clk);
      #1;
      n++;
      if (n > wait_limit) begin
        abort_run($sformatf("Timed out waiting for stat_ack to rise for stream %0d.", sel));
      end
    end
    count    = stat_count;
    stat_req = 1'b0;
    n = 0;
    while (stat_ack) begin
      @(posedge clk);
      #1;
      n++;
      if (n > wait_limit) begin
        abort_run($sformatf("Timed out waiting for stat_ack to fall for stream %0d.", sel));
      end
    end
  endtask

  initial begin
    logic [stat_width-1:0] count;
    clk       = 1'b0;
    rst_n     = 1'b0;
    s_tdata   = '0;
    s_tvalid  = '0;
    s_tlast   = '0;
    m_tready  = 1'b0;
    stat_req  = 1'b0;
    stat_sel  = '0;
    lfsr      = 32'hf749;
    stream_en = '0;
    gaps_on   = 1'b0;
    bp_on     = 1'b0;
    in_pkt    = 1'b0;
    cur_tid   = '0;
    load_vectors();
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_bit(stat_ack, 1'b0, "stat_ack after reset");
    check_bit(m_tvalid, 1'b0, "m_tvalid after reset");
    for (int s = 0; s < nr_of_streams; s++) begin
      check_bit(s_tready[s], 1'b0, $sformatf("s_tready[%0d] after reset", s));
    end

    // Stream 0 goes first so the grant is parked on it while stalled.
    queue_packets(1);
    plan_rr_order();
    stream_en = nr_of_streams'(1);
    wait_out_valid();
    stream_en = '1;
    run_until_idle(1'b0, "the phase one preload");
    m_tready = 1'b1;
    run_until_idle(1'b1, "the preloaded packets on the output");

    // Random gaps and back-pressure.
    queue_packets(2);
    gaps_on = 1'b1;
    bp_on   = 1'b1;
    run_until_idle(1'b1, "the phase two traffic");
    bp_on    = 1'b0;
    m_tready = 1'b1;

    for (int s = 0; s < nr_of_streams; s++) begin
      read_count(s, count);
      check_count(count, stat_width'(exp_cnt[s]), $sformatf("packet count of stream %0d", s));
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== pkt_mux_top.sv ====
`timescale 1ns/1ns

module pkt_mux_top #(
  parameter int fifo_depth_p    = 16,
  parameter int nr_of_streams_p = pkt_mux_pkg::nr_of_streams
) (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic [nr_of_streams_p*pkt_mux_pkg::tdata_width-1:0] s_tdata,
  input  logic [nr_of_streams_p-1:0]                       s_tvalid,
  input  logic [nr_of_streams_p-1:0]                       s_tlast,
  output logic [nr_of_streams_p-1:0]                       s_tready,
  output logic [pkt_mux_pkg::tdata_width-1:0]              m_tdata,
  output logic                                             m_tvalid,
  output logic                                             m_tlast,
  output logic [pkt_mux_pkg::tid_width-1:0]                m_tid,
  input  logic                                             m_tready,
  input  logic                                             stat_req,
  input  logic [pkt_mux_pkg::tid_width-1:0]                stat_sel,
  output logic                                             stat_ack,
  output logic [pkt_mux_pkg::stat_width-1:0]               stat_count
);
  import pkt_mux_pkg::*;

  axis_if fifo_link [nr_of_streams_p] ();
  axis_if out_link ();

  // One input FIFO per stream.
  for (genvar i = 0; i < nr_of_streams_p; i++) begin : g_fifo
    axis_fifo #(
      .fifo_depth_p (fifo_depth_p)
    ) i_axis_fifo (
      .clk      (clk),
      .rst_n    (rst_n),
      .s_tdata  (s_tdata[i*tdata_width +: tdata_width]),
      .s_tvalid (s_tvalid[i]),
      .s_tlast  (s_tlast[i]),
      .s_tready (s_tready[i]),
      .m        (fifo_link[i])
    );
  end

  axis_mux_rr #(
    .nr_of_streams_p (nr_of_streams_p)
  ) i_axis_mux_rr (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_links (fifo_link),
    .out_link (out_link),
    .m_tid    (m_tid)
  );

  pkt_stats #(
    .nr_of_streams_p (nr_of_streams_p)
  ) i_pkt_stats (
    .clk        (clk),
    .rst_n      (rst_n),
    .mon        (out_link),
    .m_tid      (m_tid),
    .stat_req   (stat_req),
    .stat_sel   (stat_sel),
    .stat_ack   (stat_ack),
    .stat_count (stat_count)
  );

  assign m_tdata         = out_link.tdata;
  assign m_tvalid        = out_link.tvalid;
  assign m_tlast         = out_link.tlast;
  assign out_link.tready = m_tready;

endmodule

// ==== pkt_stats.sv ====
`timescale 1ns/1ns

module pkt_stats #(
  parameter int nr_of_streams_p = pkt_mux_pkg::nr_of_streams
) (
  input  logic                              clk,
  input  logic                              rst_n,
  axis_if.monitor                           mon,
  input  logic [pkt_mux_pkg::tid_width-1:0]  m_tid,
  input  logic                              stat_req,
  input  logic [pkt_mux_pkg::tid_width-1:0]  stat_sel,
  output logic                              stat_ack,
  output logic [pkt_mux_pkg::stat_width-1:0] stat_count
);
  import pkt_mux_pkg::*;

  logic [stat_width-1:0] pkt_cnt [nr_of_streams_p];
  logic                  pkt_done;

  // A packet completes when its last beat leaves the output.
  assign pkt_done = mon.tvalid && mon.tready && mon.tlast;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < nr_of_streams_p; i++) begin
        pkt_cnt[i] <= '0;
      end
    end else if (pkt_done) begin
      pkt_cnt[m_tid] <= pkt_cnt[m_tid] + 1'b1;
    end
  end

  // Ack follows req by one clock in both directions.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stat_ack <= 1'b0;
    end else begin
      stat_ack <= stat_req;
    end
  end

  // Count is captured on the edge that raises ack.
  always_ff @(posedge clk) begin
    if (stat_req && !stat_ack) begin
      stat_count <= pkt_cnt[stat_sel];
    end
  end

endmodule

// ==== axis_mux_rr.sv ====
`timescale 1ns/1ns

module axis_mux_rr #(
  parameter int nr_of_streams_p = pkt_mux_pkg::nr_of_streams
) (
  input  logic                             clk,
  input  logic                             rst_n,
  axis_if.sink                             in_links [nr_of_streams_p],
  axis_if.source                           out_link,
  output logic [pkt_mux_pkg::tid_width-1:0] m_tid
);
  import pkt_mux_pkg::*;

  arb_state_e           state;
  logic [tid_width-1:0] ptr;
  logic [tid_width-1:0] ptr_next;

  logic [tdata_width-1:0]     in_tdata [nr_of_streams_p];
  logic [nr_of_streams_p-1:0] in_tvalid;
  logic [nr_of_streams_p-1:0] in_tlast;
  logic [nr_of_streams_p-1:0] in_tready;

  logic                   out_tvalid;
  logic [tdata_width-1:0] out_tdata;
  logic                   out_tlast;
  logic [tid_width-1:0]   out_tid;

  logic take;
  logic accept;

  // Flatten the link array so it can be indexed by the pointer.
  for (genvar i = 0; i < nr_of_streams_p; i++) begin : g_in
    assign in_tdata[i]       = in_links[i].tdata;
    assign in_tvalid[i]      = in_links[i].tvalid;
    assign in_tlast[i]       = in_links[i].tlast;
    assign in_links[i].tready = in_tready[i];
  end

  assign ptr_next = (ptr == tid_width'(nr_of_streams_p - 1)) ? '0 : ptr + 1'b1;

  // Room in the output stage, either empty or draining this cycle.
  assign take   = (state == arb_locked) && (!out_tvalid || out_link.tready);
  assign accept = take && in_tvalid[ptr];

  always_comb begin
    in_tready      = '0;
    in_tready[ptr] = take;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= arb_scan;
      ptr   <= '0;
    end else begin
      case (state)
        arb_scan: begin
          if (in_tvalid[ptr]) begin
            state <= arb_locked;
          end else begin
            ptr <= ptr_next;
          end
        end
        arb_locked: begin
          // Grant is released only after the whole packet has gone.
          if (accept && in_tlast[ptr]) begin
            state <= arb_scan;
            ptr   <= ptr_next;
          end
        end
        default: begin
          state <= arb_scan;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_tvalid <= 1'b0;
    end else if (accept) begin
      out_tvalid <= 1'b1;
    end else if (out_link.tready) begin
      out_tvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_tdata <= in_tdata[ptr];
      out_tlast <= in_tlast[ptr];
      out_tid   <= ptr;
    end
  end

  assign out_link.tvalid = out_tvalid;
  assign out_link.tdata  = out_tdata;
  assign out_link.tlast  = out_tlast;
  assign m_tid           = out_tid;

endmodule

// ==== axis_fifo.sv ====
`timescale 1ns/1ns

module axis_fifo #(
  parameter int fifo_depth_p = 16
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [pkt_mux_pkg::tdata_width-1:0] s_tdata,
  input  logic                               s_tvalid,
  input  logic                               s_tlast,
  output logic                               s_tready,
  axis_if.source                             m
);
  import pkt_mux_pkg::*;

  localparam int ptr_width = $clog2(fifo_depth_p);
  localparam int cnt_width = ptr_width + 1;

  // Each entry holds tlast above the data byte.
  logic [tdata_width:0] mem [fifo_depth_p];

  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [cnt_width-1:0] count;
  logic [cnt_width-1:0] count_next;
  logic                 wr_en;
  logic                 rd_en;
  logic                 empty;

  assign wr_en = s_tvalid && s_tready;
  assign rd_en = m.tvalid && m.tready;
  assign empty = (count == '0);

  always_comb begin
    count_next = count;
    if (wr_en && !rd_en) begin
      count_next = count + 1'b1;
    end else if (rd_en && !wr_en) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      s_tready <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count_next;
      // Ready drops on the same edge the last free slot fills.
      s_tready <= (count_next != cnt_width'(fifo_depth_p));
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= {s_tlast, s_tdata};
    end
  end

  assign m.tvalid = !empty;
  assign m.tdata  = mem[rd_ptr][tdata_width-1:0];
  assign m.tlast  = mem[rd_ptr][tdata_width];

endmodule

// ==== axis_if.sv ====
`timescale 1ns/1ns

interface axis_if;
  import pkt_mux_pkg::*;

  logic [tdata_width-1:0] tdata;
  logic                   tvalid;
  logic                   tready;
  logic                   tlast;

  modport source (
    output tdata,
    output tvalid,
    output tlast,
    input  tready
  );

  modport sink (
    input  tdata,
    input  tvalid,
    input  tlast,
    output tready
  );

  // Passive view for counters and checkers.
  modport monitor (
    input tdata,
    input tvalid,
    input tready,
    input tlast
  );

endinterface

// ==== pkt_mux_pkg.sv ====
package pkt_mux_pkg;

  // Number of input streams into the mux.
  localparam int nr_of_streams = 4;

  // Data bits carried per beat.
  localparam int tdata_width = 8;

  // Source id width on the output.
  localparam int tid_width = $clog2(nr_of_streams);

  // Width of each packet counter, wraps on overflow.
  localparam int stat_width = 16;

  // Arbiter states.
  typedef enum logic {
    arb_scan,
    arb_locked
  } arb_state_e;

endpackage
